//--- rtl/masked_alu_pkg.sv
//----------------------------------------------------------------------
// Shared definitions for the two-share Boolean-masked ALU
// Word width, prefix depth, PRNG seed, op codes and pipeline payloads
//----------------------------------------------------------------------
`default_nettype none

package masked_alu_pkg;

  localparam int XLEN          = 32;
  localparam int PREFIX_LEVELS = 5;   // log2(XLEN) Kogge-Stone levels

  // One share or one word of randomness
  typedef logic [XLEN-1:0] word_t;

  localparam word_t PRNG_SEED = 32'h6789ABCD;

  // Operation code
  typedef logic [1:0] alu_op_t;

  localparam alu_op_t OP_XOR = 2'd0;
  localparam alu_op_t OP_AND = 2'd1;
  localparam alu_op_t OP_ADD = 2'd2;
  localparam alu_op_t OP_SUB = 2'd3;

  // Two Boolean shares whose XOR is the true value
  typedef struct packed {
    word_t s0;
    word_t s1;
  } share_pair_t;

  // Request as seen on the input handshake
  typedef struct packed {
    alu_op_t     op;
    share_pair_t rs1;
    share_pair_t rs2;
  } alu_req_t;

  // State carried down the prefix pipeline
  typedef struct packed {
    alu_op_t     op;
    share_pair_t xr;   // Masked a ^ b kept for the final sum
    share_pair_t g;    // Masked carry generate
    share_pair_t p;    // Masked carry propagate
    word_t       gs;   // Refresh word for the next gadget
  } prefix_payload_t;

endpackage

`default_nettype wire

//--- rtl/masked_operand_prep.sv
//----------------------------------------------------------------------
// Operand preparation for the masked ALU
// LFSR refresh source, sub share inversion, first XOR/AND gadget layer
// and the slot 0 pipeline register
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_operand_prep (
  input  logic                            g_clk,
  input  logic                            g_resetn,
  input  logic                            i_advance,
  input  logic                            i_req_valid,
  input  masked_alu_pkg::alu_req_t        i_req,
  output logic                            o_valid,
  output masked_alu_pkg::prefix_payload_t o_data
);

  import masked_alu_pkg::*;

  word_t           prng;          // LFSR state
  word_t           n_prng;        // Next LFSR value used as fresh mask
  logic            n_prng_lsb;
  logic            accept;
  logic            is_sub;
  logic            is_arith;
  word_t           b1;            // rs2 share 1 after optional inversion
  share_pair_t     mxor;
  share_pair_t     mand;
  share_pair_t     gen;
  share_pair_t     prop;
  logic            u0;
  logic            u1;
  prefix_payload_t payload;
  logic            valid_q;
  prefix_payload_t data_q;

  assign accept = i_advance & i_req_valid;

  // Feedback taps 31, 21, 1, 0
  assign n_prng_lsb = prng[31] ~^ prng[21] ~^ prng[1] ~^ prng[0];
  assign n_prng     = {prng[XLEN-2:0], n_prng_lsb};

  // Only step when a request is taken, so every item sees a new mask
  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      prng <= PRNG_SEED;
    end else if (accept) begin
      prng <= n_prng;
    end
  end

  assign is_sub   = (i_req.op == OP_SUB);
  assign is_arith = (i_req.op == OP_ADD) || is_sub;

  // a - b = a + ~b + 1 and inverting one share inverts the true value
  assign b1 = is_sub ? ~i_req.rs2.s1 : i_req.rs2.s1;

  always_comb begin
    mxor.s0 = i_req.rs1.s0 ^ i_req.rs2.s0;
    mxor.s1 = i_req.rs1.s1 ^ b1;

    // Non-threshold AND gadget refreshed by the next LFSR word
    mand.s0 = n_prng ^ (i_req.rs1.s0 & b1) ^ (i_req.rs1.s0 | ~i_req.rs2.s0);
    mand.s1 = n_prng ^ (i_req.rs1.s1 & b1) ^ (i_req.rs1.s1 | ~i_req.rs2.s0);
  end

  // Carry-in folded into the bit 0 generate for sub
  assign u0 = mand.s0[0] ^ (mxor.s0[0] & is_sub);
  assign u1 = mand.s1[0] ^ (mxor.s1[0] & is_sub);

  always_comb begin
    gen.s0 = {mand.s0[XLEN-1:1], u0};
    gen.s1 = {mand.s1[XLEN-1:1], u1};

    // Logic ops keep p at zero so g holds the AND value down the chain
    if (is_arith) begin
      prop = mxor;
    end else begin
      prop = '0;
    end

    payload.op = i_req.op;
    payload.xr = mxor;
    payload.g  = gen;
    payload.p  = prop;
    payload.gs = n_prng;
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      valid_q <= 1'b0;
    end else if (i_advance) begin
      valid_q <= i_req_valid;
    end
  end

  // Payload register
  always_ff @(posedge g_clk) begin
    if (i_advance) begin
      data_q <= payload;
    end
  end

  assign o_valid = valid_q;
  assign o_data  = data_q;

endmodule

`default_nettype wire

//--- rtl/masked_prefix_stage.sv
//----------------------------------------------------------------------
// One registered Kogge-Stone level over masked generate/propagate
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_prefix_stage #(
  parameter int LEVEL = 0   // Span of this level is 2**LEVEL bits
) (
  input  logic                            g_clk,
  input  logic                            g_resetn,
  input  logic                            i_advance,
  input  logic                            i_valid,
  input  masked_alu_pkg::prefix_payload_t i_data,
  output logic                            o_valid,
  output masked_alu_pkg::prefix_payload_t o_data
);

  import masked_alu_pkg::*;

  localparam int SHIFT = 1 << LEVEL;
  localparam bit LAST  = (LEVEL == PREFIX_LEVELS - 1);

  share_pair_t     gj;        // Generate from the lower group
  share_pair_t     pj;        // Propagate from the lower group
  share_pair_t     g_nx;
  share_pair_t     p_nx;
  prefix_payload_t nxt;
  logic            valid_q;
  prefix_payload_t data_q;

  always_comb begin
    gj.s0 = i_data.g.s0 << SHIFT;
    gj.s1 = i_data.g.s1 << SHIFT;

    // Propagate is no longer needed after the last level
    if (LAST) begin
      pj = '0;
    end else begin
      pj.s0 = i_data.p.s0 << SHIFT;
      pj.s1 = i_data.p.s1 << SHIFT;
    end
  end

  always_comb begin
    // g ^= gj & p, the existing g share acts as the refresh
    g_nx.s0 = i_data.g.s0 ^ (gj.s0 & i_data.p.s1) ^ (gj.s0 | ~i_data.p.s0);
    g_nx.s1 = i_data.g.s1 ^ (gj.s1 & i_data.p.s1) ^ (gj.s1 | ~i_data.p.s0);

    // p &= pj, refreshed by the running gs word
    p_nx.s0 = i_data.gs ^ (i_data.p.s0 & pj.s1) ^ (i_data.p.s0 | ~pj.s0);
    p_nx.s1 = i_data.gs ^ (i_data.p.s1 & pj.s1) ^ (i_data.p.s1 | ~pj.s0);

    nxt.op = i_data.op;
    nxt.xr = i_data.xr;
    nxt.g  = g_nx;
    nxt.p  = p_nx;
    nxt.gs = i_data.p.s0;    // Next refresh word
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      valid_q <= 1'b0;
    end else if (i_advance) begin
      valid_q <= i_valid;
    end
  end

  always_ff @(posedge g_clk) begin
    if (i_advance) begin
      data_q <= nxt;
    end
  end

  assign o_valid = valid_q;
  assign o_data  = data_q;

endmodule

`default_nettype wire

//--- rtl/masked_result_assemble.sv
//----------------------------------------------------------------------
// Result assembly for the masked ALU
// Final carry merge for add/sub and per-operation result select
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_result_assemble (
  input  logic                            i_valid,
  input  masked_alu_pkg::prefix_payload_t i_data,
  output logic                            o_rd_valid,
  output masked_alu_pkg::share_pair_t     o_rd
);

  import masked_alu_pkg::*;

  logic        is_sub;
  word_t       gsh0;        // Carries into each bit, share 0
  word_t       gsh1;        // Carries into each bit, share 1
  share_pair_t sum;
  share_pair_t xr_fresh;

  assign is_sub = (i_data.op == OP_SUB);

  always_comb begin
    // Carry into bit i is the group generate of bits i-1..0
    gsh0 = {i_data.g.s0[XLEN-2:0], 1'b0};
    gsh1 = {i_data.g.s1[XLEN-2:0], is_sub};   // Carry-in of the +1 for sub

    sum.s0 = i_data.xr.s0 ^ gsh0;
    sum.s1 = i_data.xr.s1 ^ gsh1;

    // Same word on both shares leaves the true value unchanged
    xr_fresh.s0 = i_data.xr.s0 ^ i_data.gs;
    xr_fresh.s1 = i_data.xr.s1 ^ i_data.gs;
  end

  always_comb begin
    case (i_data.op)
      OP_XOR:  o_rd = xr_fresh;
      OP_AND:  o_rd = i_data.g;    // p was zero, so g still holds a & b
      default: o_rd = sum;         // add and sub
    endcase
  end

  assign o_rd_valid = i_valid;

endmodule

`default_nettype wire

//--- rtl/masked_alu_top.sv
//----------------------------------------------------------------------
// Pipelined two-share masked ALU top level
// Operand prep, unrolled prefix stages, result assembly, global stall
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_alu_top (
  input  logic                        g_clk,
  input  logic                        g_resetn,
  input  logic                        i_req_valid,
  input  masked_alu_pkg::alu_req_t    i_req,
  input  logic                        i_rd_ready,
  output logic                        o_req_ready,
  output logic                        o_rd_valid,
  output masked_alu_pkg::share_pair_t o_rd
);

  import masked_alu_pkg::*;

  logic            advance;     // Shared enable for every pipeline register
  logic            stage_valid [0:PREFIX_LEVELS];
  prefix_payload_t stage_data  [0:PREFIX_LEVELS];

  // Pipeline moves unless the last slot holds a result nobody takes
  assign advance     = !stage_valid[PREFIX_LEVELS] || i_rd_ready;
  assign o_req_ready = advance;

  masked_operand_prep prep_inst (
    .g_clk       (g_clk),
    .g_resetn    (g_resetn),
    .i_advance   (advance),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_valid     (stage_valid[0]),
    .o_data      (stage_data[0])
  );

  // Stage k doubles the carry span, 1, 2, 4, 8, 16 bits
  for (genvar k = 0; k < PREFIX_LEVELS; k++) begin : g_stage
    masked_prefix_stage #(
      .LEVEL (k)
    ) stage_inst (
      .g_clk     (g_clk),
      .g_resetn  (g_resetn),
      .i_advance (advance),
      .i_valid   (stage_valid[k]),
      .i_data    (stage_data[k]),
      .o_valid   (stage_valid[k+1]),
      .o_data    (stage_data[k+1])
    );
  end

  masked_result_assemble assemble_inst (
    .i_valid    (stage_valid[PREFIX_LEVELS]),
    .i_data     (stage_data[PREFIX_LEVELS]),
    .o_rd_valid (o_rd_valid),
    .o_rd       (o_rd)
  );

endmodule

`default_nettype wire

//--- dv/masked_alu_chk.sv
//----------------------------------------------------------------------
// Concurrent assertions for the masked ALU handshake and reset state
// Bound into the top level
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_alu_chk (
  input logic                        g_clk,
  input logic                        g_resetn,
  input logic                        i_rd_ready,
  input logic                        o_req_ready,
  input logic                        o_rd_valid,
  input masked_alu_pkg::share_pair_t o_rd
);

  int unsigned fail_count = 0;   // Read by the testbench summary

  // A result not taken stays valid with the same shares
  rd_hold_a: assert property (
    @(posedge g_clk) disable iff (!g_resetn)
    (o_rd_valid && !i_rd_ready) |=> (o_rd_valid && $stable(o_rd))
  ) else begin
    $error("o_rd changed or dropped while stalled");
    fail_count++;
  end

  rd_reset_a: assert property (
    @(posedge g_clk) !g_resetn |=> !o_rd_valid
  ) else begin
    $error("o_rd_valid high after a reset cycle");
    fail_count++;
  end

  // Global stall, the input opens whenever the last slot can move
  req_ready_a: assert property (
    @(posedge g_clk) disable iff (!g_resetn)
    o_req_ready == (!o_rd_valid || i_rd_ready)
  ) else begin
    $error("o_req_ready differs from the stall rule");
    fail_count++;
  end

endmodule

bind masked_alu_top masked_alu_chk chk_inst (
  .g_clk       (g_clk),
  .g_resetn    (g_resetn),
  .i_rd_ready  (i_rd_ready),
  .o_req_ready (o_req_ready),
  .o_rd_valid  (o_rd_valid),
  .o_rd        (o_rd)
);

`default_nettype wire

//--- dv/masked_alu_tb.sv
//----------------------------------------------------------------------
// Testbench for the pipelined masked ALU
// Stimulus table, reference model, timed, stalled and refresh runs
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_alu_tb;

  import masked_alu_pkg::*;

  localparam int LATENCY = 6;   // Acceptance edge to result transfer edge
  localparam int KIND_TIMED   = 0;
  localparam int KIND_STALL   = 1;
  localparam int KIND_REFRESH = 2;
  localparam int REFRESH_IDX  = 3;   // An AND row, issued twice with equal shares

  logic        g_clk;
  logic        g_resetn;
  logic        i_req_valid;
  alu_req_t    i_req;
  logic        i_rd_ready;
  logic        o_req_ready;
  logic        o_rd_valid;
  share_pair_t o_rd;

  // Stimulus table, one row per vector
  string   tbl_name [$];
  alu_op_t tbl_op   [$];
  word_t   tbl_a    [$];
  word_t   tbl_b    [$];
  word_t   tbl_exp  [$];

  // Requests in flight, oldest first
  int      exp_idx   [$];
  int      exp_kind  [$];
  int      exp_cycle [$];

  word_t       refresh_s0 [$];
  logic        stall_pat [0:63];
  logic [1:0]  ready_mode;   // 0 held low, 1 held high, 2 random
  integer      seed;
  int          cycle;
  int          limit;
  int          errors;
  int          tests;
  int          issued;
  int          received;
  logic        prev_stall;
  share_pair_t prev_rd;

  masked_alu_top masked_alu_top_inst (
    .g_clk       (g_clk),
    .g_resetn    (g_resetn),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .i_rd_ready  (i_rd_ready),
    .o_req_ready (o_req_ready),
    .o_rd_valid  (o_rd_valid),
    .o_rd        (o_rd)
  );

  initial g_clk = 1'b0;
  always #10 g_clk = ~g_clk;

  function automatic word_t true_result(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      OP_XOR:  return a ^ b;
      OP_AND:  return a & b;
      OP_ADD:  return a + b;
      default: return a - b;
    endcase
  endfunction

  task automatic compare(input string name, input word_t expected, input word_t actual,
                         inout bit ok);
    if (actual !== expected) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic add_row(input string name, input alu_op_t op, input word_t a,
                         input word_t b, input word_t exp);
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
    tbl_exp.push_back(exp);
    if (true_result(op, a, b) !== exp) begin
      $display("table row %s lists %h but the operation gives %h", name, exp,
               true_result(op, a, b));
      errors++;
    end
  endtask

  task automatic load_table();
    add_row("xor_mixed",   OP_XOR, 32'hDEADBEEF, 32'h12345678, 32'hCC99E897);
    add_row("xor_ones",    OP_XOR, 32'hFFFFFFFF, 32'h00000000, 32'hFFFFFFFF);
    add_row("xor_self",    OP_XOR, 32'hA5A5A5A5, 32'hA5A5A5A5, 32'h00000000);
    add_row("and_mixed",   OP_AND, 32'hF0F0F0F0, 32'h3C3C3C3C, 32'h30303030);
    add_row("and_ones",    OP_AND, 32'hFFFFFFFF, 32'h89ABCDEF, 32'h89ABCDEF);
    add_row("and_zero",    OP_AND, 32'h00000000, 32'hFFFFFFFF, 32'h00000000);
    add_row("add_small",   OP_ADD, 32'h00000005, 32'h00000007, 32'h0000000C);
    add_row("add_carry",   OP_ADD, 32'hFFFFFFFF, 32'h00000001, 32'h00000000);  // Full chain
    add_row("add_alt",     OP_ADD, 32'h55555555, 32'hAAAAAAAB, 32'h00000000);
    add_row("add_msb",     OP_ADD, 32'h80000000, 32'h80000000, 32'h00000000);
    add_row("add_half",    OP_ADD, 32'h0000FFFF, 32'h00000001, 32'h00010000);
    add_row("add_mixed",   OP_ADD, 32'h12345678, 32'h9ABCDEF0, 32'hACF13568);
    add_row("sub_small",   OP_SUB, 32'h0000000A, 32'h00000003, 32'h00000007);
    add_row("sub_zero_one", OP_SUB, 32'h00000000, 32'h00000001, 32'hFFFFFFFF);
    add_row("sub_equal",   OP_SUB, 32'hDEADBEEF, 32'hDEADBEEF, 32'h00000000);
    add_row("sub_borrow",  OP_SUB, 32'h80000000, 32'h00000001, 32'h7FFFFFFF);
    add_row("sub_mixed",   OP_SUB, 32'h12345678, 32'h9ABCDEF0, 32'h77777788);
  endtask

  // Split both operands into shares and hold the request until accepted
  task automatic send_request(input int idx, input int kind, input word_t m1, input word_t m2);
    alu_req_t req;
    req.op     = tbl_op[idx];
    req.rs1.s0 = m1;
    req.rs1.s1 = tbl_a[idx] ^ m1;
    req.rs2.s0 = m2;
    req.rs2.s1 = tbl_b[idx] ^ m2;
    i_req_valid <= 1'b1;
    i_req       <= req;
    do begin
      @(posedge g_clk);
    end while (!o_req_ready);
    exp_idx.push_back(idx);
    exp_kind.push_back(kind);
    exp_cycle.push_back(cycle);
    issued++;
  endtask

  task automatic wait_for_drain();
    while (exp_idx.size() != 0) begin
      @(posedge g_clk);
    end
    @(posedge g_clk);
  endtask

  task automatic collect_result();
    int    idx;
    int    kind;
    int    lat;
    word_t got;
    bit    ok;
    if (exp_idx.size() == 0) begin
      $display("a result came out with no request outstanding at cycle %0d", cycle);
      errors++;
      return;
    end
    idx  = exp_idx.pop_front();
    kind = exp_kind.pop_front();
    lat  = cycle - exp_cycle.pop_front();
    got  = o_rd.s0 ^ o_rd.s1;   // Unmasked value
    ok   = 1'b1;
    compare(tbl_name[idx], tbl_exp[idx], got, ok);
    if (kind == KIND_TIMED) begin
      compare({tbl_name[idx], "_latency"}, LATENCY, lat, ok);
    end
    if (kind == KIND_REFRESH) begin
      refresh_s0.push_back(o_rd.s0);
    end
    received++;
    tests++;
    $display("%s (%s): %s", tbl_name[idx],
             (kind == KIND_TIMED) ? "timed" : (kind == KIND_STALL) ? "stall" : "refresh",
             ok ? "ok" : "mismatch");
  endtask

  // Output monitor, sees the values from before each edge
  always @(posedge g_clk) begin
    if (g_resetn) begin
      if (o_req_ready !== (!o_rd_valid || i_rd_ready)) begin
        $display("o_req_ready broke the stall rule at cycle %0d", cycle);
        errors++;
      end
      if (prev_stall && (!o_rd_valid || o_rd !== prev_rd)) begin
        $display("stalled result changed or vanished at cycle %0d", cycle);
        errors++;
      end
      if (o_rd_valid && i_rd_ready) begin
        collect_result();
      end
      prev_stall = o_rd_valid && !i_rd_ready;
      prev_rd    = o_rd;
    end
  end

  always @(posedge g_clk) begin
    case (ready_mode)
      2'd0:    i_rd_ready <= 1'b0;
      2'd1:    i_rd_ready <= 1'b1;
      default: i_rd_ready <= stall_pat[cycle % 64];
    endcase
  end

  always @(posedge g_clk) begin
    cycle <= cycle + 1;
    if (cycle >= limit) begin
      $display("run stopped after %0d cycles with %0d results missing", cycle,
               issued - received);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    word_t r;
    word_t m1;
    word_t m2;
    bit    ok;
    seed        = 32'h26c8;
    errors      = 0;
    tests       = 0;
    issued      = 0;
    received    = 0;
    cycle       = 0;
    prev_stall  = 1'b0;
    prev_rd     = '0;
    g_resetn    = 1'b0;
    i_req_valid = 1'b0;
    i_req       = '0;
    i_rd_ready  = 1'b0;
    ready_mode  = 2'd0;
    load_table();
    for (int i = 0; i < 64; i++) begin
      r = $random(seed);
      stall_pat[i] = r[0] | (i % 4 == 3);   // Ready at least every fourth cycle
    end
    limit = (2 * tbl_name.size() + 2) * 8 + 100;

    repeat (8) @(posedge g_clk);
    g_resetn <= 1'b1;
    @(posedge g_clk);

    // Output held, yet the empty pipeline still takes requests
    ok = 1'b1;
    compare("reset_rd_valid", '0, o_rd_valid, ok);
    compare("reset_req_ready", 32'd1, o_req_ready, ok);
    tests++;
    $display("reset_state: %s", ok ? "ok" : "mismatch");

    ready_mode <= 2'd1;
    repeat (2) @(posedge g_clk);
    for (int i = 0; i < tbl_name.size(); i++) begin
      m1 = $random(seed);
      m2 = $random(seed);
      send_request(i, KIND_TIMED, m1, m2);
    end
    i_req_valid <= 1'b0;
    wait_for_drain();

    ready_mode <= 2'd2;
    for (int i = 0; i < tbl_name.size(); i++) begin
      m1 = $random(seed);
      m2 = $random(seed);
      send_request(i, KIND_STALL, m1, m2);
    end
    i_req_valid <= 1'b0;
    wait_for_drain();

    // Same shares twice, only the LFSR word differs
    ready_mode <= 2'd1;
    m1 = $random(seed);
    m2 = $random(seed);
    send_request(REFRESH_IDX, KIND_REFRESH, m1, m2);
    send_request(REFRESH_IDX, KIND_REFRESH, m1, m2);
    i_req_valid <= 1'b0;
    wait_for_drain();
    tests++;
    if (refresh_s0.size() != 2) begin
      $display("refresh run returned %0d results instead of 2", refresh_s0.size());
      errors++;
    end else if (refresh_s0[0] === refresh_s0[1]) begin
      $display("refresh run gave the same share 0 twice, %h", refresh_s0[0]);
      errors++;
    end else begin
      $display("refresh_shares: ok");
    end

    repeat (2) @(posedge g_clk);
    if (received != issued) begin
      $display("%0d requests accepted but %0d results received", issued, received);
      errors++;
    end
    $display("tests %0d, errors %0d, assertion failures %0d", tests, errors,
             masked_alu_top_inst.chk_inst.fail_count);
    if (errors == 0 && masked_alu_top_inst.chk_inst.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/masked_alu_pkg.sv
rtl/masked_operand_prep.sv
rtl/masked_prefix_stage.sv
rtl/masked_result_assemble.sv
rtl/masked_alu_top.sv
dv/masked_alu_chk.sv
dv/masked_alu_tb.sv
